//--- sgb_reg_pkg.sv
// register map of the console-side window
// the bus decode keeps addr[15:11] and addr[3:0], so offsets are sparse
package sgb_reg_pkg;

  typedef logic [15:0] reg_addr_t;  // offset after decode, bits 10:4 zeroed
  typedef logic [7:0]  byte_t;      // one data byte on the console bus
  typedef logic [7:0]  ctl_t;       // control word at 6003
  typedef logic [1:0]  clk_mult_t;  // cpu divisor select /16 /20 /28 /36
  typedef logic [1:0]  player_mask_t; // 0,1,3 -> 1,2,4 players

  // --------------------------------------------------------------------------
  // offsets
  // --------------------------------------------------------------------------
  localparam reg_addr_t ADDR_PKTRDY   = 16'h6002; // R  packet ready flag
  localparam reg_addr_t ADDR_CTL      = 16'h6003; // W  control
  localparam reg_addr_t ADDR_PAD0     = 16'h6004; // W  pads at 6004..6007
  localparam reg_addr_t ADDR_VER      = 16'h600F; // R  version
  localparam reg_addr_t ADDR_PKT_BASE = 16'h7000; // R  packet bytes 7000..700F

  // --------------------------------------------------------------------------
  // control word fields
  // --------------------------------------------------------------------------
  localparam int CTL_RUN_BIT    = 7;  // 1 releases the handheld cpu
  localparam int CTL_PLAYER_LSB = 4;  // player mask at 5:4
  localparam int CTL_MULT_LSB   = 0;  // divisor select at 1:0

  // only bits 7, 5:4 and 1:0 are stored
  localparam ctl_t CTL_WR_MASK = 8'hB3;

  // reset values
  localparam ctl_t  CTL_RESET = 8'h01;  // held in reset, divisor /20
  localparam byte_t VERSION   = 8'h61;

endpackage

//--- sgb_link_pkg.sv
// joypad / serial link types
// the P1 select pair doubles as a two-wire serial channel
package sgb_link_pkg;

  // pad state, all active low
  //   7:4 buttons  (start select b a)
  //   3:0 d-pad    (down up left right)
  typedef logic [7:0] pad_t;

  localparam int   NUM_PADS     = 4;
  localparam pad_t PAD_RELEASED = 8'hFF; // nothing pressed

  typedef logic [1:0] pad_id_t;    // currently selected pad

  // --------------------------------------------------------------------------
  // packet geometry
  // --------------------------------------------------------------------------
  localparam int PKT_BYTES = 16;   // 128 bits per packet

  typedef logic [3:0] pkt_index_t; // byte within a packet
  typedef logic [6:0] bit_pos_t;   // bit within a packet, byte in 6:3

  // --------------------------------------------------------------------------
  // P1 select codes as driven by the handheld
  // --------------------------------------------------------------------------
  typedef logic [1:0] p1_sel_t;

  localparam p1_sel_t P1_START = 2'b00; // reset pulse, opens a packet
  localparam p1_sel_t P1_BIT1  = 2'b01; // data bit 1, also selects buttons
  localparam p1_sel_t P1_BIT0  = 2'b10; // data bit 0, also selects d-pad
  localparam p1_sel_t P1_IDLE  = 2'b11; // neither line low, shows pad id

  // serial receiver
  typedef enum logic [1:0] {
    LINK_IDLE,  // joypad mode
    LINK_RECV,  // waiting for the next data bit
    LINK_WAIT   // waiting for the 11 between bits
  } link_state_t;

endpackage

//--- sgb_link_if.sv
`timescale 1ns/10ps

// register block <-> joypad/serial link
interface sgb_link_if;

  sgb_link_pkg::pad_t         pads [sgb_link_pkg::NUM_PADS]; // masked pad regs
  sgb_reg_pkg::player_mask_t  player_mask;  // control bits 5:4
  sgb_link_pkg::pkt_index_t   pkt_index;    // byte picked by the bus address
  sgb_reg_pkg::byte_t         pkt_byte;     // that byte, combinational
  logic                       pkt_done;     // one cycle, packet closed ok

  // register side
  modport mmio (
    output pads,
    output player_mask,
    output pkt_index,
    input  pkt_byte,
    input  pkt_done
  );

  // link side
  modport link (
    input  pads,
    input  player_mask,
    input  pkt_index,
    output pkt_byte,
    output pkt_done
  );

endinterface

//--- sgb_clock_gen.sv
`timescale 1ns/10ps

// cpu clock edge from the base clock
// a skip cycle every SKIP_PERIOD+1 clocks trims the base rate, the divider
// then counts 16/20/28/36 live clocks per cpu edge
module sgb_clock_gen #(
  parameter int SKIP_PERIOD = 736   // 736 for sgb2 timing, 175 for sgb1
) (
  input  logic                   CLK,
  input  logic                   cpu_ireset_r,
  input  sgb_reg_pkg::clk_mult_t clk_mult,     // from control, async to bus edge
  output logic                   clk_cpu_edge  // one base clock wide
);

  localparam int SKP_W = $clog2(SKIP_PERIOD + 1);

  logic [SKP_W-1:0]       skp_ctr_r;
  logic [5:0]             cpu_ctr_r;  // up to 35
  logic [5:0]             cpu_term;   // last count of the current ratio
  logic [1:0]             bus_ctr_r;  // cpu edges within a bus cycle
  sgb_reg_pkg::clk_mult_t mult_r;     // divisor in use
  logic                   skp_ast;
  logic                   cpu_ast;
  logic                   bus_edge;

  always_comb begin
    case (mult_r)
      2'd0:    cpu_term = 6'd15;  // /4 cpu
      2'd1:    cpu_term = 6'd19;  // /5, the default
      2'd2:    cpu_term = 6'd27;  // /7
      default: cpu_term = 6'd35;  // /9
    endcase
  end

  assign skp_ast  = (skp_ctr_r == SKP_W'(SKIP_PERIOD));
  assign cpu_ast  = ~skp_ast & (cpu_ctr_r == cpu_term); // never on a skip
  assign bus_edge = clk_cpu_edge & (&bus_ctr_r);        // every 4th cpu edge

  always_ff @(posedge CLK) begin
    if (cpu_ireset_r) begin
      skp_ctr_r    <= '0;
      cpu_ctr_r    <= '0;
      bus_ctr_r    <= '0;
      clk_cpu_edge <= 1'b0;
      mult_r       <= sgb_reg_pkg::clk_mult_t'(sgb_reg_pkg::CTL_RESET); // /20
    end else begin
      skp_ctr_r <= skp_ast ? '0 : skp_ctr_r + 1'b1;

      // skip cycle freezes the divider for one clock
      if (!skp_ast) begin
        cpu_ctr_r <= cpu_ast ? '0 : cpu_ctr_r + 1'b1;
      end

      clk_cpu_edge <= cpu_ast;  // registered so the edge is glitch free

      if (clk_cpu_edge) begin
        bus_ctr_r <= bus_ctr_r + 1'b1;
      end

      // ratio only changes on a bus boundary
      if (bus_edge) begin
        mult_r <= clk_mult;
      end
    end
  end

endmodule

//--- sgb_mmio_regs.sv
`timescale 1ns/10ps

// console-side register window
//   6002 R  pktrdy      6003 W  control      6004-6007 W  pads
//   600F R  version     7000-700F R  packet bytes
module sgb_mmio_regs (
  input  logic                CLK,
  input  logic                cpu_ireset_r,
  input  logic                snes_rd_start,  // pulse at start of a read
  input  logic                snes_wr_end,    // pulse at end of a write
  input  logic [23:0]         snes_addr,
  input  sgb_reg_pkg::byte_t  data_in,
  output sgb_reg_pkg::byte_t  data_out,
  output logic                cpu_rst,
  output sgb_reg_pkg::clk_mult_t clk_mult,
  sgb_link_if.mmio            link
);

  sgb_reg_pkg::ctl_t      ctl_r;
  sgb_link_pkg::pad_t     pad_r [sgb_link_pkg::NUM_PADS];
  logic                   pktrdy_r;
  logic                   pkt_clear_r;  // read of 7000 seen last cycle
  sgb_reg_pkg::reg_addr_t dec_addr;
  logic                   dec_hit;
  logic                   rd_hit;
  logic                   wr_hit;
  logic                   is_pad;
  logic                   is_pkt;
  sgb_reg_pkg::player_mask_t player_mask;

  // --------------------------------------------------------------------------
  // address decode
  // --------------------------------------------------------------------------
  assign dec_hit  = ~snes_addr[22];  // only the low half of the map
  assign dec_addr = {snes_addr[15:11], 7'h00, snes_addr[3:0]}; // 10:4 ignored
  assign rd_hit   = snes_rd_start & dec_hit;
  assign wr_hit   = snes_wr_end & dec_hit;
  assign is_pad   = (dec_addr[15:2] == sgb_reg_pkg::ADDR_PAD0[15:2]);
  assign is_pkt   = (dec_addr[15:4] == sgb_reg_pkg::ADDR_PKT_BASE[15:4]);

  // control fields out
  assign player_mask = ctl_r[sgb_reg_pkg::CTL_PLAYER_LSB +: 2];
  assign clk_mult    = ctl_r[sgb_reg_pkg::CTL_MULT_LSB +: 2];
  assign cpu_rst     = ~ctl_r[sgb_reg_pkg::CTL_RUN_BIT]; // run bit low holds cpu

  // link side
  assign link.pads        = pad_r;
  assign link.player_mask = player_mask;
  assign link.pkt_index   = snes_addr[3:0]; // byte lookup runs every cycle

  // --------------------------------------------------------------------------
  // control and pads
  // --------------------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (cpu_ireset_r) begin
      ctl_r <= sgb_reg_pkg::CTL_RESET;
      for (int i = 0; i < sgb_link_pkg::NUM_PADS; i++) begin
        pad_r[i] <= sgb_link_pkg::PAD_RELEASED;
      end
    end else begin
      if (wr_hit && dec_addr == sgb_reg_pkg::ADDR_CTL) begin
        ctl_r <= data_in & sgb_reg_pkg::CTL_WR_MASK;  // unused bits stay 0
      end
      if (wr_hit && is_pad) begin
        pad_r[dec_addr[1:0]] <= data_in;
      end
      // disabled players read as released, wins over a write
      // a pad is off when its id cannot be reached by (id+1) & mask
      for (int i = 0; i < sgb_link_pkg::NUM_PADS; i++) begin
        if (|(2'(i) & ~player_mask)) begin
          pad_r[i] <= sgb_link_pkg::PAD_RELEASED;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // packet ready
  // --------------------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (cpu_ireset_r) begin
      pktrdy_r    <= 1'b0;
      pkt_clear_r <= 1'b0;
    end else begin
      pkt_clear_r <= rd_hit & (dec_addr == sgb_reg_pkg::ADDR_PKT_BASE);
      pktrdy_r    <= (pktrdy_r & ~pkt_clear_r) | link.pkt_done; // set wins
    end
  end

  // --------------------------------------------------------------------------
  // read data
  // --------------------------------------------------------------------------
  // latched at read start so late writes cannot move the bus mid cycle
  always_ff @(posedge CLK) begin
    if (rd_hit) begin
      if (dec_addr == sgb_reg_pkg::ADDR_PKTRDY) begin
        data_out <= {7'h00, pktrdy_r};
      end else if (dec_addr == sgb_reg_pkg::ADDR_VER) begin
        data_out <= sgb_reg_pkg::VERSION;
      end else if (is_pkt) begin
        data_out <= link.pkt_byte;
      end
      // unmapped offsets keep the old value
    end
  end

endmodule

//--- sgb_joypad_link.sv
`timescale 1ns/10ps

// P1 joypad mux plus the serial packet receiver
// the handheld drives the two select lines, we answer on the four inputs
//   idle : 11 shows ~id, 10 d-pad, 01 buttons, 01->1x steps the id
//   serial : 00 opens, then per bit 10 (0) or 01 (1) each followed by 11,
//            closed by 11 then 10 after bit 127
module sgb_joypad_link (
  input  logic                  CLK,
  input  logic                  cpu_ireset_r,
  input  logic                  clk_cpu_edge,
  input  sgb_link_pkg::p1_sel_t p1i,
  output logic [3:0]            p1o,
  output logic                  idl,   // handheld may halt
  sgb_link_if.link              link
);

  sgb_link_pkg::link_state_t state_r;
  sgb_link_pkg::link_state_t next_r;  // where WAIT goes on its release code
  sgb_link_pkg::p1_sel_t     prev_r;  // p1i at the last cpu edge
  sgb_link_pkg::pad_id_t     id_r;
  sgb_link_pkg::bit_pos_t    bit_pos_r;
  sgb_reg_pkg::byte_t        pkt_r [sgb_link_pkg::PKT_BYTES];
  logic                      pkt_done_r;
  sgb_link_pkg::pad_t        cur_pad;
  logic                      p1_change;
  logic                      wait_close; // WAIT is expecting the final 10

  // --------------------------------------------------------------------------
  // joypad output
  // --------------------------------------------------------------------------
  assign cur_pad = link.pads[id_r];

  always_comb begin
    if (p1i == sgb_link_pkg::P1_IDLE) begin
      p1o = {2'b11, ~id_r};  // F E D C for pads 0..3
    end else begin
      // a low select line enables its nibble, both low ANDs them
      p1o = ({4{p1i[1]}} | cur_pad[7:4]) & ({4{p1i[0]}} | cur_pad[3:0]);
    end
  end

  assign idl = (state_r == sgb_link_pkg::LINK_IDLE)
             | ((state_r == sgb_link_pkg::LINK_WAIT) & (bit_pos_r == '0));

  assign link.pkt_byte = pkt_r[link.pkt_index];
  assign link.pkt_done = pkt_done_r;

  assign p1_change  = clk_cpu_edge & (p1i != prev_r);
  assign wait_close = (next_r == sgb_link_pkg::LINK_IDLE);

  // --------------------------------------------------------------------------
  // receiver
  // --------------------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (cpu_ireset_r) begin
      state_r    <= sgb_link_pkg::LINK_IDLE;
      next_r     <= sgb_link_pkg::LINK_IDLE;
      prev_r     <= sgb_link_pkg::P1_IDLE;
      id_r       <= '0;
      bit_pos_r  <= '0;
      pkt_done_r <= 1'b0;
      for (int i = 0; i < sgb_link_pkg::PKT_BYTES; i++) begin
        pkt_r[i] <= '0;
      end
    end else begin
      pkt_done_r <= 1'b0;

      if (clk_cpu_edge) begin
        prev_r <= p1i;
      end

      if (p1_change) begin
        if (p1i == sgb_link_pkg::P1_START) begin
          // 00 restarts a packet from any state
          bit_pos_r <= '0;
          next_r    <= sgb_link_pkg::LINK_RECV;
          state_r   <= sgb_link_pkg::LINK_WAIT;
        end else begin
          case (state_r)
            sgb_link_pkg::LINK_IDLE: begin
              if (~prev_r[1] & p1i[1]) begin  // 01 -> 10/11
                id_r <= (id_r + 1'b1) & link.player_mask;
              end
            end
            sgb_link_pkg::LINK_RECV: begin
              if (^p1i) begin  // 10 or 01 carries a bit, 11 is a nop
                pkt_r[bit_pos_r[6:3]][bit_pos_r[2:0]] <= p1i[0]; // lsb first
                bit_pos_r <= bit_pos_r + 1'b1;
                next_r    <= (&bit_pos_r) ? sgb_link_pkg::LINK_WAIT
                                          : sgb_link_pkg::LINK_RECV;
                state_r   <= sgb_link_pkg::LINK_WAIT;
              end
            end
            sgb_link_pkg::LINK_WAIT: begin
              // 11 releases a bit wait, 10 is the closing code
              if (p1i == {1'b1, ~wait_close}) begin
                pkt_done_r <= wait_close;
                next_r     <= sgb_link_pkg::LINK_IDLE;
                state_r    <= next_r;
              end else if (^p1i) begin
                state_r <= sgb_link_pkg::LINK_IDLE;  // out of sequence, abort
              end
            end
            default: state_r <= sgb_link_pkg::LINK_IDLE;
          endcase
        end
      end
    end
  end

endmodule

//--- sgb_icd2.sv
`timescale 1ns/10ps

// cartridge-side link of the handheld adapter
// console bus registers, cpu clock edge, joypad and serial packets
module sgb_icd2 #(
  parameter int SKIP_PERIOD = 736
) (
  input  logic                  CLK,
  input  logic                  cpu_ireset_r,
  // console bus
  input  logic                  snes_rd_start,
  input  logic                  snes_wr_end,
  input  logic [23:0]           snes_addr,
  input  sgb_reg_pkg::byte_t    data_in,
  output sgb_reg_pkg::byte_t    data_out,
  // handheld side
  output logic                  cpu_rst,
  output logic                  clk_cpu_edge,
  input  sgb_link_pkg::p1_sel_t p1i,
  output logic [3:0]            p1o,
  output logic                  idl
);

  sgb_reg_pkg::clk_mult_t clk_mult;  // control bits 1:0

  sgb_link_if link_if ();

  sgb_clock_gen #(
    .SKIP_PERIOD (SKIP_PERIOD)
  ) u_clock_gen (
    .CLK          (CLK),
    .cpu_ireset_r (cpu_ireset_r),
    .clk_mult     (clk_mult),
    .clk_cpu_edge (clk_cpu_edge)
  );

  sgb_mmio_regs u_mmio_regs (
    .CLK           (CLK),
    .cpu_ireset_r  (cpu_ireset_r),
    .snes_rd_start (snes_rd_start),
    .snes_wr_end   (snes_wr_end),
    .snes_addr     (snes_addr),
    .data_in       (data_in),
    .data_out      (data_out),
    .cpu_rst       (cpu_rst),
    .clk_mult      (clk_mult),
    .link          (link_if.mmio)
  );

  sgb_joypad_link u_joypad_link (
    .CLK          (CLK),
    .cpu_ireset_r (cpu_ireset_r),
    .clk_cpu_edge (clk_cpu_edge),
    .p1i          (p1i),
    .p1o          (p1o),
    .idl          (idl),
    .link         (link_if.link)
  );

endmodule

//--- tb_sgb_checker.sv
`timescale 1ns/10ps

// watches the DUT outputs and compares them with the expectations
// strobed in by the stimulus driver, one compare per strobe
//   r  data_out == exp            o  p1o == exp[3:0], idl == arg[0]
//   c  cpu_rst == exp[0]          e  count cpu edges over arg clocks
module tb_sgb_checker (
  input  logic               CLK,
  input  sgb_reg_pkg::byte_t data_out,
  input  logic [3:0]         p1o,
  input  logic               idl,
  input  logic               cpu_rst,
  input  logic               clk_cpu_edge,
  input  logic               chk_stb,     // one cycle, compare on this edge
  input  logic [7:0]         chk_kind,    // opcode letter
  input  logic [15:0]        chk_arg,
  input  sgb_reg_pkg::byte_t chk_exp,
  output int                 check_cnt,
  output int                 error_cnt,
  output logic               rate_busy    // edge window still open
);

  int   check_r = 0;
  int   err_r = 0;
  int   rate_left = 0;   // base clocks left in the window
  int   rate_cnt = 0;
  int   rate_exp = 0;
  logic rate_busy_r = 1'b0;

  assign check_cnt = check_r;
  assign error_cnt = err_r;
  assign rate_busy = rate_busy_r;

  // --------------------------------------------------------------------------
  // cpu edge window, about SKIP_PERIOD/(SKIP_PERIOD+1) of clocks/divisor edges
  // --------------------------------------------------------------------------
  always @(posedge CLK) begin
    if (rate_busy_r) begin
      if (clk_cpu_edge) rate_cnt = rate_cnt + 1;
      rate_left = rate_left - 1;
      if (rate_left == 0) begin
        check_r = check_r + 1;
        // one edge of slack for where the window cuts the divider
        if (rate_cnt < rate_exp - 1 || rate_cnt > rate_exp + 1) begin
          err_r = err_r + 1;
          $display("FAILED at %0t: %0d cpu edges, expected %0d", $time, rate_cnt, rate_exp);
        end
        rate_busy_r <= 1'b0;
      end
    end

    if (chk_stb) begin
      case (chk_kind)
        "r": begin
          check_r = check_r + 1;
          if (data_out !== chk_exp) begin
            err_r = err_r + 1;
            $display("FAILED at %0t: data_out %h, expected %h", $time, data_out, chk_exp);
          end
        end
        "o": begin
          check_r = check_r + 1;
          if (p1o !== chk_exp[3:0] || idl !== chk_arg[0]) begin
            err_r = err_r + 1;
            $display("FAILED at %0t: p1o %h idl %b, expected p1o %h idl %b",
                     $time, p1o, idl, chk_exp[3:0], chk_arg[0]);
          end
        end
        "c": begin
          check_r = check_r + 1;
          if (cpu_rst !== chk_exp[0]) begin
            err_r = err_r + 1;
            $display("FAILED at %0t: cpu_rst %b, expected %b", $time, cpu_rst, chk_exp[0]);
          end
        end
        "e": begin
          rate_left = int'(chk_arg);
          rate_cnt  = 0;
          rate_exp  = int'(chk_exp);
          rate_busy_r <= 1'b1;
        end
        default: begin
          err_r = err_r + 1;
          $display("checker got an unknown check kind %c", chk_kind);
        end
      endcase
    end
  end

endmodule

//--- tb_sgb_icd2.sv
`timescale 1ns/10ps

// testbench for sgb_icd2
// reads one operation per line from sgb_icd2_cases.txt and drives the DUT,
// every compare is handed to the checker through a one-cycle strobe
module tb_sgb_icd2;

  localparam int EDGE_TIMEOUT = 80;  // base clocks per cpu edge, /36 plus skip
  localparam int COMMENT_CHAR = 35;  // '#'

  logic               CLK;
  logic               cpu_ireset_r;
  logic               snes_rd_start;
  logic               snes_wr_end;
  logic [23:0]        snes_addr;
  sgb_reg_pkg::byte_t data_in;
  sgb_reg_pkg::byte_t data_out;
  logic               cpu_rst;
  logic               clk_cpu_edge;
  logic [1:0]         p1i;
  logic [3:0]         p1o;
  logic               idl;

  logic               chk_stb;
  logic [7:0]         chk_kind;
  logic [15:0]        chk_arg;
  sgb_reg_pkg::byte_t chk_exp;
  int                 check_cnt;
  int                 chk_errors;
  logic               rate_busy;

  int                 run_errors = 0;  // case file trouble
  int                 timeouts = 0;
  sgb_reg_pkg::byte_t pkt_q [$];       // bytes sent in the current packet

  sgb_icd2 #(.SKIP_PERIOD(736)) dut0 (
    .CLK (CLK), .cpu_ireset_r (cpu_ireset_r),
    .snes_rd_start (snes_rd_start), .snes_wr_end (snes_wr_end),
    .snes_addr (snes_addr), .data_in (data_in), .data_out (data_out),
    .cpu_rst (cpu_rst), .clk_cpu_edge (clk_cpu_edge),
    .p1i (p1i), .p1o (p1o), .idl (idl)
  );

  tb_sgb_checker chk0 (
    .CLK (CLK), .data_out (data_out), .p1o (p1o), .idl (idl),
    .cpu_rst (cpu_rst), .clk_cpu_edge (clk_cpu_edge),
    .chk_stb (chk_stb), .chk_kind (chk_kind), .chk_arg (chk_arg),
    .chk_exp (chk_exp), .check_cnt (check_cnt), .error_cnt (chk_errors),
    .rate_busy (rate_busy)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;  // 20 ns base clock
  end

  // --------------------------------------------------------------------------
  // bus and P1 drivers, all called and returning 2 ns after a rising edge
  // --------------------------------------------------------------------------
  task automatic bus_write(input logic [23:0] addr, input sgb_reg_pkg::byte_t data);
    snes_addr   = addr;
    data_in     = data;
    snes_wr_end = 1'b1;   // write lands on this edge
    @(posedge CLK);
    #2 snes_wr_end = 1'b0;
  endtask

  task automatic bus_read(input logic [23:0] addr);
    snes_addr     = addr;
    snes_rd_start = 1'b1;  // data_out valid from the next cycle
    @(posedge CLK);
    #2 snes_rd_start = 1'b0;
  endtask

  task automatic expect_value(input logic [7:0] kind, input logic [15:0] arg,
                              input sgb_reg_pkg::byte_t exp);
    chk_kind = kind;
    chk_arg  = arg;
    chk_exp  = exp;
    chk_stb  = 1'b1;
    @(posedge CLK);
    #2 chk_stb = 1'b0;
  endtask

  // the link samples p1i on the same edges that are counted here
  task automatic wait_cpu_edges(input int n);
    int cnt;
    int cyc;
    cnt = 0;
    cyc = 0;
    if (timeouts != 0) return;
    while (cnt < n && cyc < n * EDGE_TIMEOUT) begin
      @(posedge CLK);
      cyc++;
      if (clk_cpu_edge) cnt++;
    end
    #2;
    if (cnt < n) begin
      $display("timeout: only %0d of %0d cpu edges came at %0t", cnt, n, $time);
      timeouts++;
    end else begin
      repeat (2) @(posedge CLK);  // pkt_done reaches pktrdy two clocks later
      #2;
    end
  endtask

  task automatic drive_p1(input logic [1:0] sel);
    p1i = sel;
    wait_cpu_edges(1);
  endtask

  // half 0 opens with 00 then 11, half 1 closes with 10 (LINK_WAIT -> LINK_IDLE)
  task automatic send_half(input logic half, input logic [63:0] bytes);
    int i;
    int j;
    sgb_reg_pkg::byte_t b;
    if (!half) begin
      pkt_q.delete();
      drive_p1(2'b00);
      drive_p1(2'b11);
    end
    for (i = 7; i >= 0; i--) begin
      b = bytes[i*8 +: 8];  // leftmost byte of the field goes first
      pkt_q.push_back(b);
      for (j = 0; j < 8; j++) begin
        drive_p1(b[j] ? 2'b01 : 2'b10);  // lsb first
        drive_p1(2'b11);
      end
    end
    if (half) drive_p1(2'b10);
  endtask

  task automatic read_packet();
    int i;
    if (pkt_q.size() != sgb_link_pkg::PKT_BYTES) begin
      $display("case file sent %0d packet bytes instead of 16", pkt_q.size());
      run_errors++;
    end else begin
      for (i = 0; i < sgb_link_pkg::PKT_BYTES; i++) begin
        bus_read({8'h00, sgb_reg_pkg::ADDR_PKT_BASE} + 24'(i));
        expect_value("r", 16'h0, pkt_q[i]);
      end
    end
  endtask

  task automatic measure_rate(input logic [15:0] clocks, input sgb_reg_pkg::byte_t edges);
    int guard;
    guard = 0;
    expect_value("e", clocks, edges);
    while (rate_busy && guard < int'(clocks) + 50) begin
      @(posedge CLK);
      #2 guard++;
    end
    if (rate_busy) begin
      $display("timeout: the cpu edge window never closed");
      timeouts++;
    end
  endtask

  task automatic run_op(input logic [7:0] op, input logic [23:0] f1, input logic [63:0] f2);
    case (op)
      "w": bus_write(f1, f2[7:0]);
      "r": begin
        bus_read(f1);
        expect_value("r", 16'h0, f2[7:0]);
      end
      "p": begin
        p1i = f1[1:0];
        wait_cpu_edges(int'(f2));
      end
      "o": expect_value("o", f1[15:0], f2[7:0]);
      "c": expect_value("c", 16'h0, f2[7:0]);
      "k": begin
        bus_read({8'h00, sgb_reg_pkg::ADDR_PKTRDY});
        expect_value("r", 16'h0, f2[7:0]);
      end
      "s": send_half(f1[0], f2);
      "q": read_packet();
      "e": measure_rate(f1[15:0], f2[7:0]);
      default: begin
        $display("unknown opcode %c in the case file", op);
        run_errors++;
      end
    endcase
  endtask

  task automatic skip_line(input int fd);
    int c;
    c = 0;
    while (c != 10 && c != -1) c = $fgetc(fd);
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial begin
    int          fd;
    int          c;
    int          n;
    logic        done;
    logic [23:0] f1;
    logic [63:0] f2;
    cpu_ireset_r  = 1'b1;
    snes_rd_start = 1'b0;
    snes_wr_end   = 1'b0;
    snes_addr     = '0;
    data_in       = '0;
    p1i           = 2'b11;  // both select lines high
    chk_stb       = 1'b0;
    chk_kind      = '0;
    chk_arg       = '0;
    chk_exp       = '0;
    f1            = '0;
    f2            = '0;
    done          = 1'b0;
    repeat (16) @(posedge CLK);
    #2 cpu_ireset_r = 1'b0;

    fd = $fopen("sgb_icd2_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open sgb_icd2_cases.txt");
      run_errors++;
    end else begin
      while (!done && timeouts == 0) begin
        c = $fgetc(fd);
        if (c == -1) begin
          done = 1'b1;
        end else if (c == COMMENT_CHAR) begin
          skip_line(fd);
        end else if (c > 32) begin  // anything but blanks starts an operation
          n = $fscanf(fd, "%h %h", f1, f2);
          if (n != 2) begin
            $display("case file line for opcode %c lacks its two fields", 8'(c));
            run_errors++;
            done = 1'b1;
          end else begin
            run_op(8'(c), f1, f2);
          end
        end
      end
      $fclose(fd);
    end

    repeat (2) @(posedge CLK);
    $display("checks %0d  errors %0d  timeouts %0d", check_cnt, chk_errors + run_errors,
             timeouts);
    if (chk_errors + run_errors + timeouts == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- sgb_icd2_cases.txt
# op field1 field2, both hex: w addr data | r addr exp | p p1i edges | o idl p1o
# c - cpu_rst | k - pktrdy | s half 8-bytes | q - - | e clocks edges
e 190 14
r 00600f 61
r 0067ff 61
k 0 00
c 0 1
w 006003 80
c 0 0
# one player, pad 1 stays released
w 006004 5a
w 006005 00
p 2 1
o 1 a
p 1 1
o 1 5
p 3 1
o 1 f
# four players, id steps on 01 -> 11
w 006003 b0
p 1 1
p 3 1
o 1 e
p 2 1
o 1 f
p 1 1
o 1 f
p 3 1
o 1 d
p 1 1
p 3 1
o 1 c
p 1 1
p 3 1
o 1 f
# serial packet
s 0 0123456789abcdef
s 1 fedcba9876543210
k 0 01
q 0 0
k 0 00
# stray 01 while waiting for 11
p 0 1
o 1 0
p 3 1
o 0 f
p 2 1
o 0 a
p 1 1
o 1 5
k 0 00

//--- sgb_icd2.f
sgb_reg_pkg.sv
sgb_link_pkg.sv
sgb_link_if.sv
sgb_clock_gen.sv
sgb_mmio_regs.sv
sgb_joypad_link.sv
sgb_icd2.sv
tb_sgb_checker.sv
tb_sgb_icd2.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps \
  --top-module tb_sgb_icd2 -f sgb_icd2.f || { echo "build failed"; exit 1; }

out=$(./obj_dir/Vtb_sgb_icd2)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx '=== PASS ===' && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
